/* axi_defs_pkg.sv */
`default_nettype none

package axi_defs_pkg;

   // Bus geometry
   localparam int AXI_ADDR_W     = 32;
   localparam int AXI_DATA_W     = 32;
   localparam int AXI_LEN_W      = 8;
   localparam int AXI_ID_W       = 1;
   localparam int AXI_STRB_BYTES = AXI_DATA_W / 8;
   localparam int OFFSET_W       = $clog2(AXI_STRB_BYTES);

   // Burst limits
   localparam int AXI_MAX_BEATS  = 16;
   localparam int AXI_BOUNDARY   = 4096;
   localparam int AXI_BOUNDARY_W = $clog2(AXI_BOUNDARY);

   // ARBURST encodings
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   // ARSIZE is log2 of the bytes per beat
   localparam logic [2:0] AXI_SIZE = 3'($clog2(AXI_STRB_BYTES));

endpackage

`default_nettype wire

/* rd_defs_pkg.sv */
`default_nettype none

package rd_defs_pkg;

   // Simple read port geometry
   localparam int LEN_W      = 12;
   localparam int NUM_PORTS  = 2;
   localparam int PORT_IDX_W = $clog2(NUM_PORTS);

   // Wide enough for both output words and bus beats of one request
   localparam int WORD_CNT_W = 11;

   // Adapter FSM
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      PLAN = 2'd1,
      ADDR = 2'd2,
      DATA = 2'd3
   } adapter_state_e;

endpackage

`default_nettype wire

/* transfer_planner.sv */
`timescale 1ns/1ps
`default_nettype none

module transfer_planner
   import axi_defs_pkg::*;
   import rd_defs_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire logic                  start_i,
   input  wire logic                  burst_done_i,
   input  wire logic [AXI_ADDR_W-1:0] addr_i,
   input  wire logic [LEN_W-1:0]      len_i,
   output logic      [AXI_ADDR_W-1:0] burst_addr_o,
   output logic      [AXI_LEN_W-1:0]  burst_len_o,
   output logic                       last_burst_o,
   output logic      [WORD_CNT_W-1:0] word_count_o
);

   logic [AXI_ADDR_W-1:0]          cur_addr_q;
   logic [WORD_CNT_W-1:0]          beats_left_q;
   logic [WORD_CNT_W-1:0]          word_cnt_q;
   logic [AXI_ADDR_W-1:0]          end_addr;
   logic [AXI_ADDR_W-OFFSET_W-1:0] start_word;
   logic [AXI_ADDR_W-OFFSET_W-1:0] end_word;
   logic [WORD_CNT_W-1:0]          start_beats;
   logic [WORD_CNT_W-1:0]          start_words;
   logic [WORD_CNT_W-1:0]          bound_beats;
   logic [WORD_CNT_W-1:0]          burst_beats;

   // Span from the aligned first beat to the beat holding the last byte
   assign end_addr    = addr_i + AXI_ADDR_W'(len_i) - 1'b1;
   assign start_word  = addr_i[AXI_ADDR_W-1:OFFSET_W];
   assign end_word    = end_addr[AXI_ADDR_W-1:OFFSET_W];
   assign start_beats = WORD_CNT_W'(end_word - start_word + 1'b1);

   // Output words depend on the length only
   assign start_words = WORD_CNT_W'(({1'b0, len_i} + (LEN_W+1)'(AXI_STRB_BYTES - 1)) >> OFFSET_W);

   // Beats left before the next 4 KiB page
   assign bound_beats =
      WORD_CNT_W'((AXI_BOUNDARY - cur_addr_q[AXI_BOUNDARY_W-1:0]) >> OFFSET_W);

   always_comb begin
      burst_beats = beats_left_q;
      if (burst_beats > WORD_CNT_W'(AXI_MAX_BEATS)) begin
         burst_beats = WORD_CNT_W'(AXI_MAX_BEATS);
      end
      if (burst_beats > bound_beats) begin
         burst_beats = bound_beats;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cur_addr_q   <= '0;
         beats_left_q <= '0;
         word_cnt_q   <= '0;
      end else if (start_i) begin
         cur_addr_q   <= {start_word, {OFFSET_W{1'b0}}};
         beats_left_q <= start_beats;
         word_cnt_q   <= start_words;
      end else if (burst_done_i) begin
         cur_addr_q   <= cur_addr_q + (AXI_ADDR_W'(burst_beats) << OFFSET_W);
         beats_left_q <= beats_left_q - burst_beats;
      end
   end

   assign burst_addr_o = cur_addr_q;
   assign burst_len_o  = AXI_LEN_W'(burst_beats - 1'b1);
   assign last_burst_o = (burst_beats == beats_left_q);
   assign word_count_o = word_cnt_q;

   // A finished burst stayed within the beat cap and its 4 KiB page
   a_burst_legal: assert property (@(posedge clk_i) disable iff (rst_i)
      burst_done_i |-> (burst_len_o < AXI_LEN_W'(AXI_MAX_BEATS)) &&
         (burst_addr_o[AXI_BOUNDARY_W-1:0] + (burst_len_o + 1) * AXI_STRB_BYTES
            <= AXI_BOUNDARY));

endmodule

`default_nettype wire

/* burst_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_aligner
   import axi_defs_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire logic                  start_i,
   input  wire logic [OFFSET_W-1:0]   offset_i,
   input  wire logic                  beat_valid_i,
   input  wire logic [AXI_DATA_W-1:0] beat_data_i,
   input  wire logic                  final_beat_i,
   output logic                       word_valid_o,
   output logic      [AXI_DATA_W-1:0] word_data_o,
   output logic                       empty_o
);

   logic [OFFSET_W-1:0]     offset_q;
   logic                    first_q;
   logic                    flush_q;
   logic [AXI_DATA_W-1:0]   carry_q;
   logic                    unaligned;
   logic [2*AXI_DATA_W-1:0] pair;
   logic [2*AXI_DATA_W-1:0] shifted;

   assign unaligned = (offset_q != '0);

   // Current beat on top of the carried beat, zeros during the flush
   assign pair    = {flush_q ? {AXI_DATA_W{1'b0}} : beat_data_i, carry_q};
   assign shifted = pair >> {offset_q, 3'b000};

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         offset_q <= '0;
         first_q  <= 1'b0;
         flush_q  <= 1'b0;
      end else if (start_i) begin
         offset_q <= offset_i;
         first_q  <= 1'b1;
         flush_q  <= 1'b0;
      end else if (beat_valid_i) begin
         first_q <= 1'b0;
         flush_q <= final_beat_i && unaligned;
      end else begin
         flush_q <= 1'b0;
      end
   end

   // Upper bytes of the last beat wait here for the next one
   always_ff @(posedge clk_i) begin
      if (beat_valid_i) begin
         carry_q <= beat_data_i;
      end
   end

   // With an offset the first beat only fills the carry
   assign word_valid_o = flush_q || (beat_valid_i && !(first_q && unaligned));
   assign word_data_o  = unaligned ? shifted[AXI_DATA_W-1:0] : beat_data_i;
   assign empty_o      = !flush_q;

endmodule

`default_nettype wire

/* axi_read_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_adapter
   import axi_defs_pkg::*;
   import rd_defs_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire logic                  req_i,
   input  wire logic [AXI_ADDR_W-1:0] addr_i,
   input  wire logic [LEN_W-1:0]      len_i,
   output logic                       ar_valid_o,
   input  wire logic                  ar_ready_i,
   output logic      [AXI_ADDR_W-1:0] ar_addr_o,
   output logic      [AXI_LEN_W-1:0]  ar_len_o,
   input  wire logic                  r_valid_i,
   input  wire logic [AXI_DATA_W-1:0] r_data_i,
   input  wire logic                  r_last_i,
   output logic                       r_ready_o,
   output logic                       strobe_o,
   output logic      [AXI_DATA_W-1:0] data_o,
   output logic                       last_o
);

   adapter_state_e        state_q;
   logic                  start;
   logic                  beat;
   logic                  burst_done;
   logic                  last_burst;
   logic                  align_empty;
   logic                  word_valid;
   logic [WORD_CNT_W-1:0] word_count;
   logic [WORD_CNT_W-1:0] words_q;

   assign start      = (state_q == IDLE) && req_i && align_empty;
   assign beat       = r_valid_i && r_ready_o;
   assign burst_done = beat && r_last_i;

   transfer_planner u_planner (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (start),
      .burst_done_i(burst_done),
      .addr_i      (addr_i),
      .len_i       (len_i),
      .burst_addr_o(ar_addr_o),
      .burst_len_o (ar_len_o),
      .last_burst_o(last_burst),
      .word_count_o(word_count)
   );

   burst_aligner u_aligner (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (start),
      .offset_i    (addr_i[OFFSET_W-1:0]),
      .beat_valid_i(beat),
      .beat_data_i (r_data_i),
      .final_beat_i(burst_done && last_burst),
      .word_valid_o(word_valid),
      .word_data_o (data_o),
      .empty_o     (align_empty)
   );

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: if (start) state_q <= PLAN;
            PLAN: state_q <= ADDR;
            ADDR: if (ar_ready_i) state_q <= DATA;
            DATA: begin
               if (burst_done) begin
                  state_q <= last_burst ? IDLE : PLAN;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Count delivered words, the flush may run past the end
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         words_q <= '0;
      end else if (start) begin
         words_q <= '0;
      end else if (strobe_o) begin
         words_q <= words_q + 1'b1;
      end
   end

   assign ar_valid_o = (state_q == ADDR);
   assign r_ready_o  = (state_q == DATA);
   assign strobe_o   = word_valid && (words_q < word_count);
   assign last_o     = strobe_o && ((words_q + WORD_CNT_W'(1)) == word_count);

   // Address request stays put while the arbiter or slave stalls
   a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o));

endmodule

`default_nettype wire

/* axi_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_arbiter
   import axi_defs_pkg::*;
   import rd_defs_pkg::*;
(
   input  wire logic                                  clk_i,
   input  wire logic                                  rst_i,
   input  wire logic [NUM_PORTS-1:0]                  ar_valid_i,
   input  wire logic [NUM_PORTS-1:0][AXI_ADDR_W-1:0]  ar_addr_i,
   input  wire logic [NUM_PORTS-1:0][AXI_LEN_W-1:0]   ar_len_i,
   input  wire logic [NUM_PORTS-1:0]                  r_ready_i,
   output logic      [NUM_PORTS-1:0]                  ar_ready_o,
   output logic      [NUM_PORTS-1:0]                  r_valid_o,
   output logic      [NUM_PORTS-1:0][AXI_DATA_W-1:0]  r_data_o,
   output logic      [NUM_PORTS-1:0]                  r_last_o,
   output logic                                       axi_arvalid_o,
   input  wire logic                                  axi_arready_i,
   output logic      [AXI_ADDR_W-1:0]                 axi_araddr_o,
   output logic      [AXI_LEN_W-1:0]                  axi_arlen_o,
   output logic      [AXI_ID_W-1:0]                   axi_arid_o,
   output logic      [2:0]                            axi_arsize_o,
   output logic      [1:0]                            axi_arburst_o,
   input  wire logic                                  axi_rvalid_i,
   output logic                                       axi_rready_o,
   input  wire logic [AXI_DATA_W-1:0]                 axi_rdata_i,
   input  wire logic                                  axi_rlast_i,
   input  wire logic [AXI_ID_W-1:0]                   axi_rid_i
);

   logic                  owner_q;
   logic [PORT_IDX_W-1:0] grant_q;
   logic [PORT_IDX_W-1:0] prio_q;
   logic [PORT_IDX_W-1:0] pick;
   logic [PORT_IDX_W-1:0] scan_idx;
   logic                  found;
   logic [NUM_PORTS-1:0]  port_sel;
   logic                  burst_end;

   // Search pending requests starting at the rotating priority
   always_comb begin
      pick     = '0;
      scan_idx = '0;
      found    = 1'b0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         scan_idx = PORT_IDX_W'((int'(prio_q) + i) % NUM_PORTS);
         if (!found && ar_valid_i[scan_idx]) begin
            pick  = scan_idx;
            found = 1'b1;
         end
      end
   end

   assign burst_end = axi_rvalid_i && axi_rready_o && axi_rlast_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         owner_q <= 1'b0;
         grant_q <= '0;
         prio_q  <= '0;
      end else if (!owner_q) begin
         if (found) begin
            owner_q <= 1'b1;
            grant_q <= pick;
            prio_q  <= PORT_IDX_W'((int'(pick) + 1) % NUM_PORTS);
         end
      end else if (burst_end) begin
         owner_q <= 1'b0;
      end
   end

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         port_sel[p] = owner_q && (grant_q == PORT_IDX_W'(p));
      end
   end

   // AR side follows the owner
   assign axi_arvalid_o = owner_q && ar_valid_i[grant_q];
   assign axi_araddr_o  = ar_addr_i[grant_q];
   assign axi_arlen_o   = ar_len_i[grant_q];
   assign axi_arid_o    = AXI_ID_W'(grant_q);
   assign axi_arsize_o  = AXI_SIZE;
   assign axi_arburst_o = BURST_INCR;
   assign ar_ready_o    = port_sel & {NUM_PORTS{axi_arready_i}};

   // R side, data shared, valid and last only to the owner
   assign axi_rready_o = owner_q && r_ready_i[grant_q];
   assign r_valid_o    = port_sel & {NUM_PORTS{axi_rvalid_i}};
   assign r_last_o     = port_sel & {NUM_PORTS{axi_rlast_i}};
   assign r_data_o     = {NUM_PORTS{axi_rdata_i}};

   // Slave must answer with the ID of the burst in flight
   a_rid_match: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_rvalid_i && axi_rready_o |-> axi_rid_i == AXI_ID_W'(grant_q));

endmodule

`default_nettype wire

/* dual_read_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_read_frontend
   import axi_defs_pkg::*;
   import rd_defs_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   // Port 0
   input  wire logic                  rd_req_0_i,
   input  wire logic [AXI_ADDR_W-1:0] rd_addr_0_i,
   input  wire logic [LEN_W-1:0]      rd_len_0_i,
   output logic                       rd_strobe_0_o,
   output logic      [AXI_DATA_W-1:0] rd_data_0_o,
   output logic                       rd_last_0_o,
   // Port 1
   input  wire logic                  rd_req_1_i,
   input  wire logic [AXI_ADDR_W-1:0] rd_addr_1_i,
   input  wire logic [LEN_W-1:0]      rd_len_1_i,
   output logic                       rd_strobe_1_o,
   output logic      [AXI_DATA_W-1:0] rd_data_1_o,
   output logic                       rd_last_1_o,
   // AXI read channels
   output logic                       axi_arvalid_o,
   input  wire logic                  axi_arready_i,
   output logic      [AXI_ADDR_W-1:0] axi_araddr_o,
   output logic      [AXI_LEN_W-1:0]  axi_arlen_o,
   output logic      [AXI_ID_W-1:0]   axi_arid_o,
   output logic      [2:0]            axi_arsize_o,
   output logic      [1:0]            axi_arburst_o,
   input  wire logic                  axi_rvalid_i,
   output logic                       axi_rready_o,
   input  wire logic [AXI_DATA_W-1:0] axi_rdata_i,
   input  wire logic                  axi_rlast_i,
   input  wire logic [AXI_ID_W-1:0]   axi_rid_i
);

   wire [NUM_PORTS-1:0]                 ar_valid;
   wire [NUM_PORTS-1:0]                 ar_ready;
   wire [NUM_PORTS-1:0][AXI_ADDR_W-1:0] ar_addr;
   wire [NUM_PORTS-1:0][AXI_LEN_W-1:0]  ar_len;
   wire [NUM_PORTS-1:0]                 r_valid;
   wire [NUM_PORTS-1:0][AXI_DATA_W-1:0] r_data;
   wire [NUM_PORTS-1:0]                 r_last;
   wire [NUM_PORTS-1:0]                 r_ready;

   axi_read_adapter u_adapter_0 (
      .clk_i(clk_i),           .rst_i(rst_i),
      .req_i(rd_req_0_i),      .addr_i(rd_addr_0_i),   .len_i(rd_len_0_i),
      .ar_valid_o(ar_valid[0]), .ar_ready_i(ar_ready[0]),
      .ar_addr_o(ar_addr[0]),  .ar_len_o(ar_len[0]),
      .r_valid_i(r_valid[0]),  .r_data_i(r_data[0]),   .r_last_i(r_last[0]),
      .r_ready_o(r_ready[0]),
      .strobe_o(rd_strobe_0_o), .data_o(rd_data_0_o),  .last_o(rd_last_0_o)
   );

   axi_read_adapter u_adapter_1 (
      .clk_i(clk_i),           .rst_i(rst_i),
      .req_i(rd_req_1_i),      .addr_i(rd_addr_1_i),   .len_i(rd_len_1_i),
      .ar_valid_o(ar_valid[1]), .ar_ready_i(ar_ready[1]),
      .ar_addr_o(ar_addr[1]),  .ar_len_o(ar_len[1]),
      .r_valid_i(r_valid[1]),  .r_data_i(r_data[1]),   .r_last_i(r_last[1]),
      .r_ready_o(r_ready[1]),
      .strobe_o(rd_strobe_1_o), .data_o(rd_data_1_o),  .last_o(rd_last_1_o)
   );

   axi_read_arbiter u_arbiter (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ar_valid_i   (ar_valid),
      .ar_addr_i    (ar_addr),
      .ar_len_i     (ar_len),
      .r_ready_i    (r_ready),
      .ar_ready_o   (ar_ready),
      .r_valid_o    (r_valid),
      .r_data_o     (r_data),
      .r_last_o     (r_last),
      .axi_arvalid_o(axi_arvalid_o),
      .axi_arready_i(axi_arready_i),
      .axi_araddr_o (axi_araddr_o),
      .axi_arlen_o  (axi_arlen_o),
      .axi_arid_o   (axi_arid_o),
      .axi_arsize_o (axi_arsize_o),
      .axi_arburst_o(axi_arburst_o),
      .axi_rvalid_i (axi_rvalid_i),
      .axi_rready_o (axi_rready_o),
      .axi_rdata_i  (axi_rdata_i),
      .axi_rlast_i  (axi_rlast_i),
      .axi_rid_i    (axi_rid_i)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   // 4 ns period
   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   // Reset held over the first two rising edges
   initial begin
      rst_o = 1'b1;
      repeat (2) @(posedge clk_o);
      #1;
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem
   import axi_defs_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire logic [1:0]            gap_i,
   input  wire logic                  arvalid_i,
   output logic                       arready_o,
   input  wire logic [AXI_ADDR_W-1:0] araddr_i,
   input  wire logic [AXI_LEN_W-1:0]  arlen_i,
   input  wire logic [AXI_ID_W-1:0]   arid_i,
   input  wire logic [2:0]            arsize_i,
   input  wire logic [1:0]            arburst_i,
   output logic                       rvalid_o,
   input  wire logic                  rready_i,
   output logic      [AXI_DATA_W-1:0] rdata_o,
   output logic                       rlast_o,
   output logic      [AXI_ID_W-1:0]   rid_o,
   output logic                       bad_burst_o
);

   logic [31:0]           rng;
   logic                  in_reset;
   logic                  busy;
   logic [AXI_ADDR_W-1:0] beat_addr;
   int                    beats_left;
   logic [AXI_ID_W-1:0]   burst_id;
   logic                  ar_fire;
   logic                  r_fire;
   logic [AXI_ADDR_W-1:0] req_addr;
   logic [AXI_LEN_W-1:0]  req_len;
   logic [AXI_ID_W-1:0]   req_id;
   logic                  req_legal;

   // Byte pattern, a hash of the full address
   function automatic logic [7:0] mem_byte(input logic [AXI_ADDR_W-1:0] a);
      logic [31:0] h;
      h = a * 32'h9E37_79B1;
      return h[31:24];
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin
      arready_o   = 1'b0;
      rvalid_o    = 1'b0;
      rdata_o     = '0;
      rlast_o     = 1'b0;
      rid_o       = '0;
      bad_burst_o = 1'b0;
      busy        = 1'b0;
      beat_addr   = '0;
      beats_left  = 0;
      burst_id    = '0;
      rng         = 32'h9223;
      forever begin
         // Handshakes taken from settled values ahead of the edge
         @(negedge clk_i);
         in_reset  = rst_i;
         ar_fire   = arvalid_i && arready_o;
         r_fire    = rvalid_o && rready_i;
         req_addr  = araddr_i;
         req_len   = arlen_i;
         req_id    = arid_i;
         // Beat cap, 4 KiB page, INCR, full width, aligned start
         req_legal = (int'(req_len) < AXI_MAX_BEATS) &&
            (int'(req_addr[AXI_BOUNDARY_W-1:0]) + (int'(req_len) + 1) * AXI_STRB_BYTES
               <= AXI_BOUNDARY) &&
            (arburst_i == BURST_INCR) && (arsize_i == AXI_SIZE) &&
            (req_addr[OFFSET_W-1:0] == '0);
         @(posedge clk_i);
         #1;
         rng = xorshift32(rng);
         if (in_reset) begin
            arready_o = 1'b0;
            rvalid_o  = 1'b0;
            rlast_o   = 1'b0;
            busy      = 1'b0;
         end else begin
            if (r_fire) begin
               beat_addr  = beat_addr + AXI_ADDR_W'(AXI_STRB_BYTES);
               beats_left = beats_left - 1;
               rvalid_o   = 1'b0;
               rlast_o    = 1'b0;
               if (beats_left == 0) begin
                  busy = 1'b0;
               end
            end
            if (ar_fire) begin
               if (!req_legal) begin
                  bad_burst_o = 1'b1;
               end
               busy       = 1'b1;
               beat_addr  = req_addr;
               beats_left = int'(req_len) + 1;
               burst_id   = req_id;
            end
            // Present the next beat unless a gap is drawn
            if (busy && !rvalid_o && (rng[1:0] >= gap_i)) begin
               rvalid_o = 1'b1;
               rdata_o  = {mem_byte(beat_addr + 32'd3), mem_byte(beat_addr + 32'd2),
                           mem_byte(beat_addr + 32'd1), mem_byte(beat_addr)};
               rlast_o  = (beats_left == 1);
               rid_o    = burst_id;
            end
            arready_o = !busy && (rng[9:8] >= gap_i);
         end
      end
   end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
   import axi_defs_pkg::*;
   import rd_defs_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 20000;

   wire                                  clk;
   wire                                  rst;
   logic [NUM_PORTS-1:0]                 req;
   logic [AXI_ADDR_W-1:0]                addr [NUM_PORTS];
   logic [LEN_W-1:0]                     len [NUM_PORTS];
   wire  [NUM_PORTS-1:0]                 strobe;
   wire  [NUM_PORTS-1:0][AXI_DATA_W-1:0] data;
   wire  [NUM_PORTS-1:0]                 last;
   logic [NUM_PORTS-1:0]                 active;
   int                                   word_idx [NUM_PORTS];
   int                                   done_cnt [NUM_PORTS];
   logic [1:0]                           gap;
   logic [31:0]                          rng;

   wire                  arvalid;
   wire                  arready;
   wire [AXI_ADDR_W-1:0] araddr;
   wire [AXI_LEN_W-1:0]  arlen;
   wire [AXI_ID_W-1:0]   arid;
   wire [2:0]            arsize;
   wire [1:0]            arburst;
   wire                  rvalid;
   wire                  rready;
   wire [AXI_DATA_W-1:0] rdata;
   wire                  rlast;
   wire [AXI_ID_W-1:0]   rid;
   wire                  bad_burst;

   tb_clock_gen clk_gen (.clk_o(clk), .rst_o(rst));

   dual_read_frontend dut (
      .clk_i(clk), .rst_i(rst),
      .rd_req_0_i(req[0]), .rd_addr_0_i(addr[0]), .rd_len_0_i(len[0]),
      .rd_strobe_0_o(strobe[0]), .rd_data_0_o(data[0]), .rd_last_0_o(last[0]),
      .rd_req_1_i(req[1]), .rd_addr_1_i(addr[1]), .rd_len_1_i(len[1]),
      .rd_strobe_1_o(strobe[1]), .rd_data_1_o(data[1]), .rd_last_1_o(last[1]),
      .axi_arvalid_o(arvalid), .axi_arready_i(arready), .axi_araddr_o(araddr),
      .axi_arlen_o(arlen), .axi_arid_o(arid), .axi_arsize_o(arsize),
      .axi_arburst_o(arburst), .axi_rvalid_i(rvalid), .axi_rready_o(rready),
      .axi_rdata_i(rdata), .axi_rlast_i(rlast), .axi_rid_i(rid)
   );

   tb_axi_mem mem (
      .clk_i(clk), .rst_i(rst), .gap_i(gap),
      .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
      .arid_i(arid), .arsize_i(arsize), .arburst_i(arburst),
      .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rlast_o(rlast),
      .rid_o(rid), .bad_burst_o(bad_burst)
   );

   // Same byte pattern as the memory model
   function automatic logic [7:0] mem_byte(input logic [AXI_ADDR_W-1:0] a);
      logic [31:0] h;
      h = a * 32'h9E37_79B1;
      return h[31:24];
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Word k of a read starts at byte a + 4k, little endian
   function automatic logic [AXI_DATA_W-1:0] expected_word(input logic [AXI_ADDR_W-1:0] a,
                                                           input int k);
      logic [AXI_DATA_W-1:0] w;
      for (int j = 0; j < AXI_STRB_BYTES; j++) begin
         w[8*j +: 8] = mem_byte(a + AXI_ADDR_W'(AXI_STRB_BYTES * k + j));
      end
      return w;
   endfunction

   // Bytes past the requested length carry no meaning
   function automatic logic [AXI_DATA_W-1:0] valid_bytes(input logic [LEN_W-1:0] n,
                                                         input int k);
      logic [AXI_DATA_W-1:0] m;
      m = '0;
      for (int j = 0; j < AXI_STRB_BYTES; j++) begin
         if (AXI_STRB_BYTES * k + j < int'(n)) begin
            m[8*j +: 8] = 8'hFF;
         end
      end
      return m;
   endfunction

   function automatic int word_total(input logic [LEN_W-1:0] n);
      return (int'(n) + AXI_STRB_BYTES - 1) / AXI_STRB_BYTES;
   endfunction

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_data(input int p, input int k, input logic [AXI_DATA_W-1:0] got,
                             input logic [AXI_DATA_W-1:0] exp,
                             input logic [AXI_DATA_W-1:0] mask);
      if (((got ^ exp) & mask) !== '0) begin
         $display("Error at %0t: port %0d word %0d data %h, expected %h (byte mask %h)",
                  $realtime, p, k, got, exp, mask);
         abort_run();
      end
   endtask

   task automatic check_last(input int p, input int k, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0t: port %0d word %0d last %b, expected %b",
                  $realtime, p, k, got, exp);
         abort_run();
      end
   endtask

   // Holds the request until the compare process has seen the last word
   task automatic issue_read(input int p, input logic [AXI_ADDR_W-1:0] a,
                             input logic [LEN_W-1:0] n);
      int start_cnt;
      int cycles;
      start_cnt = done_cnt[p];
      @(posedge clk);
      #1;
      addr[p]   = a;
      len[p]    = n;
      req[p]    = 1'b1;
      active[p] = 1'b1;
      cycles    = 0;
      while (done_cnt[p] == start_cnt) begin
         if (cycles >= TIMEOUT_CYCLES) begin
            $display("Port %0d did not finish its read of %0d bytes at %h in time", p, n, a);
            abort_run();
         end
         @(posedge clk);
         cycles++;
      end
      #1;
      req[p]    = 1'b0;
      active[p] = 1'b0;
   endtask

   task automatic run_random_pair();
      logic [AXI_ADDR_W-1:0] a0;
      logic [AXI_ADDR_W-1:0] a1;
      logic [LEN_W-1:0]      n0;
      logic [LEN_W-1:0]      n1;
      rng = xorshift32(rng);
      a0  = {18'd0, rng[13:0]};
      n0  = LEN_W'(32'd1 + rng[24:16]);
      rng = xorshift32(rng);
      a1  = {18'd0, rng[13:0]};
      n1  = LEN_W'(32'd1 + rng[24:16]);
      fork
         issue_read(0, a0, n0);
         issue_read(1, a1, n1);
      join
   endtask

   // Compare process, outputs are settled at the falling edge
   initial begin
      logic exp_last;
      for (int p = 0; p < NUM_PORTS; p++) begin
         word_idx[p] = 0;
         done_cnt[p] = 0;
      end
      forever begin
         @(negedge clk);
         if (bad_burst) begin
            $display("Memory model received a burst over 16 beats or across 4 KiB");
            abort_run();
         end
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (strobe[p]) begin
               if (!active[p]) begin
                  $display("Port %0d strobed a word with no request pending", p);
                  abort_run();
               end
               check_data(p, word_idx[p], data[p], expected_word(addr[p], word_idx[p]),
                          valid_bytes(len[p], word_idx[p]));
               exp_last = (word_idx[p] == word_total(len[p]) - 1);
               check_last(p, word_idx[p], last[p], exp_last);
               if (last[p]) begin
                  word_idx[p] = 0;
                  done_cnt[p] = done_cnt[p] + 1;
               end else begin
                  word_idx[p] = word_idx[p] + 1;
               end
            end
         end
      end
   end

   initial begin
      int cycles;
      req     = '0;
      active  = '0;
      addr[0] = '0;
      addr[1] = '0;
      len[0]  = '0;
      len[1]  = '0;
      gap     = 2'd0;
      rng     = 32'h9223;
      cycles  = 0;
      while (rst !== 1'b0) begin
         if (cycles >= 100) begin
            $display("Reset was never released");
            abort_run();
         end
         @(posedge clk);
         cycles++;
      end

      // Aligned, one word and several
      issue_read(0, 32'h0000_0100, 12'd4);
      issue_read(0, 32'h0000_0200, 12'd40);
      issue_read(1, 32'h0000_0380, 12'd16);

      // Unaligned starts with odd lengths
      issue_read(0, 32'h0000_0401, 12'd7);
      issue_read(0, 32'h0000_0502, 12'd13);
      issue_read(0, 32'h0000_0603, 12'd1);
      issue_read(1, 32'h0000_0703, 12'd2);
      issue_read(1, 32'h0000_0801, 12'd61);

      // Across a 4 KiB page and past 16 beats
      gap = 2'd1;
      issue_read(0, 32'h0000_0FE6, 12'd151);
      issue_read(1, 32'h0000_1FF0, 12'd100);

      // Both ports at once
      repeat (8) run_random_pair();

      // Heavy back-pressure on AR and R
      gap = 2'd3;
      issue_read(0, 32'h0000_2FFD, 12'd203);
      repeat (6) run_random_pair();

      if (bad_burst) begin
         $display("Memory model flagged an illegal burst");
         abort_run();
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sim.f */
axi_defs_pkg.sv
rd_defs_pkg.sv
transfer_planner.sv
burst_aligner.sv
axi_read_adapter.sv
axi_read_arbiter.sv
dual_read_frontend.sv
tb_clock_gen.sv
tb_axi_mem.sv
tb_top.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_top
RTL_TOP     ?= dual_read_frontend
FILELIST    ?= sim.f
OBJ_DIR     ?= obj_dir
PASS_MSG    ?= Done: no errors
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only -Wall

RTL_SRCS := axi_defs_pkg.sv rd_defs_pkg.sv transfer_planner.sv burst_aligner.sv \
            axi_read_adapter.sv axi_read_arbiter.sv dual_read_frontend.sv
TB_SRCS  := tb_clock_gen.sv tb_axi_mem.sv tb_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
